/* project.f */
+incdir+tb
hw/cpu_pkg.sv
hw/pipe_if.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/mips_pipeline.sv
tb/tb_mips_pipeline.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps --top-module tb_mips_pipeline \
    -f project.f -o sim_tb || { echo "build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -q "Checks failed" sim.log && { echo "simulation failed"; exit 1; }
grep -q "All checks passed" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

/* tb/tb_programs.svh */
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// Test program table
localparam int NUM_PROGS = 7;                // Zero and random entries come last
localparam int MAX_WORDS = 24;
localparam int MAX_REGS  = 20;
localparam int MAX_MEMS  = 4;

word_t prog_words [NUM_PROGS][MAX_WORDS];    // Instruction words loaded from index 0
int    prog_len   [NUM_PROGS];
int    reg_num    [NUM_PROGS][MAX_REGS];     // Register to read back
word_t reg_exp    [NUM_PROGS][MAX_REGS];
int    reg_cnt    [NUM_PROGS];
word_t mem_addr   [NUM_PROGS][MAX_MEMS];     // Byte address as used by LW and SW
word_t mem_exp    [NUM_PROGS][MAX_MEMS];
int    mem_cnt    [NUM_PROGS];
int    cur_entry;                            // Entry being filled

function automatic void start_entry(input int idx);
    cur_entry     = idx;
    prog_len[idx] = 0;
    reg_cnt[idx]  = 0;
    mem_cnt[idx]  = 0;
endfunction

function automatic void put_word(input word_t w);
    prog_words[cur_entry][prog_len[cur_entry]] = w;
    prog_len[cur_entry] = prog_len[cur_entry] + 1;
endfunction

function automatic void expect_reg(input int r, input word_t v);
    reg_num[cur_entry][reg_cnt[cur_entry]] = r;
    reg_exp[cur_entry][reg_cnt[cur_entry]] = v;
    reg_cnt[cur_entry] = reg_cnt[cur_entry] + 1;
endfunction

function automatic void expect_mem(input word_t a, input word_t v);
    mem_addr[cur_entry][mem_cnt[cur_entry]] = a;
    mem_exp[cur_entry][mem_cnt[cur_entry]]  = v;
    mem_cnt[cur_entry] = mem_cnt[cur_entry] + 1;
endfunction

function automatic void build_table();
    start_entry(0);                                      // ALU operations
    put_word(i_type(OP_ADDI, 1, 0, 16'h0007));
    put_word(i_type(OP_ADDI, 2, 0, 16'hFFFD));           // -3
    put_word(r_type(F_ADDU, 3, 1, 2));
    put_word(r_type(F_SUBU, 4, 1, 2));
    put_word(r_type(F_AND,  5, 1, 2));
    put_word(r_type(F_OR,   6, 1, 2));
    put_word(r_type(F_XOR,  7, 1, 2));
    put_word(r_type(F_SLT,  8, 2, 1));                   // Signed so -3 < 7
    put_word(r_type(F_SLT,  9, 1, 2));
    put_word(halt_word());
    expect_reg(1, 32'h0000_0007);
    expect_reg(2, 32'hFFFF_FFFD);
    expect_reg(3, 32'h0000_0004);
    expect_reg(4, 32'h0000_000A);
    expect_reg(5, 32'h0000_0005);
    expect_reg(6, 32'hFFFF_FFFF);
    expect_reg(7, 32'hFFFF_FFFA);
    expect_reg(8, 32'h0000_0001);
    expect_reg(9, 32'h0000_0000);

    start_entry(1);                                      // Dependent chain back to back
    put_word(i_type(OP_ADDI, 1, 0, 16'h0010));
    put_word(r_type(F_ADDU, 2, 1, 1));
    put_word(r_type(F_SUBU, 3, 2, 1));
    put_word(r_type(F_XOR,  4, 3, 2));
    put_word(i_type(OP_ADDI, 5, 4, 16'hFFF0));
    put_word(halt_word());
    expect_reg(1, 32'h0000_0010);
    expect_reg(2, 32'h0000_0020);
    expect_reg(3, 32'h0000_0010);
    expect_reg(4, 32'h0000_0030);
    expect_reg(5, 32'h0000_0020);

    start_entry(2);                                      // Same chain with two NOPs between
    put_word(i_type(OP_ADDI, 1, 0, 16'h0010));
    put_word(NOP_WORD);
    put_word(NOP_WORD);
    put_word(r_type(F_ADDU, 2, 1, 1));
    put_word(NOP_WORD);
    put_word(NOP_WORD);
    put_word(r_type(F_SUBU, 3, 2, 1));
    put_word(NOP_WORD);
    put_word(NOP_WORD);
    put_word(r_type(F_XOR,  4, 3, 2));
    put_word(NOP_WORD);
    put_word(NOP_WORD);
    put_word(i_type(OP_ADDI, 5, 4, 16'hFFF0));
    put_word(halt_word());
    expect_reg(1, 32'h0000_0010);
    expect_reg(2, 32'h0000_0020);
    expect_reg(3, 32'h0000_0010);
    expect_reg(4, 32'h0000_0030);
    expect_reg(5, 32'h0000_0020);

    start_entry(3);                                      // Stores and loads
    put_word(i_type(OP_ADDI, 1, 0, 16'h1234));
    put_word(i_type(OP_ADDI, 2, 0, 16'h0008));
    put_word(i_type(OP_SW,   1, 2, 16'h0004));           // mem[12] = r1
    put_word(i_type(OP_ADDI, 3, 0, 16'hBEEF));
    put_word(i_type(OP_SW,   3, 0, 16'h0000));           // mem[0] = r3
    put_word(NOP_WORD);
    put_word(i_type(OP_LW,   4, 0, 16'h000C));
    put_word(i_type(OP_LW,   5, 0, 16'h0000));
    put_word(NOP_WORD);                                  // Load-use gap
    put_word(r_type(F_ADDU, 6, 4, 5));
    put_word(halt_word());
    expect_reg(4, 32'h0000_1234);
    expect_reg(5, 32'hFFFF_BEEF);
    expect_reg(6, 32'hFFFF_D123);
    expect_mem(32'h0000_000C, 32'h0000_1234);
    expect_mem(32'h0000_0000, 32'hFFFF_BEEF);

    start_entry(4);                                      // HALT blocks later writes
    put_word(i_type(OP_ADDI, 1, 0, 16'h0055));
    put_word(i_type(OP_ADDI, 2, 1, 16'h0001));
    put_word(halt_word());
    put_word(i_type(OP_ADDI, 3, 0, 16'h0077));
    put_word(i_type(OP_ADDI, 1, 0, 16'h0099));
    expect_reg(1, 32'h0000_0055);
    expect_reg(2, 32'h0000_0056);
    expect_reg(3, 32'h0000_0000);
endfunction

`endif

/* tb/tb_mips_pipeline.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mips_pipeline;
    import cpu_pkg::*;

    localparam int IMEM_DEPTH = 64;
    localparam int DMEM_DEPTH = 64;

    logic  i_clk = 1'b0;
    logic  i_reset;
    word_t i_du_data;
    word_t i_du_inst_addr_wr;
    logic  i_du_write_en;
    logic  i_du_read_en;
    logic  o_du_halt;
    word_t o_du_regs_mem_data;
    word_t o_du_mem_data;

    integer seed = 32'h99d5b901;             // Seed for the random chain
    int     cycle_count = 0;
    int     cycle_limit = 0;                 // Zero until the table is built

    // Instruction encoders in MIPS field layout
    function automatic word_t r_type(input funct_e f, input int rd, input int rs, input int rt);
        return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'b0, f};
    endfunction

    function automatic word_t i_type(input opcode_e op, input int rt, input int rs,
                                     input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic word_t halt_word();
        return {OP_HALT, 26'b0};
    endfunction

    function automatic word_t sext16(input logic [15:0] v);
        return {{16{v[15]}}, v};             // Sign extension of an immediate
    endfunction

    `include "tb_programs.svh"

    mips_pipeline #(
        .IMEM_DEPTH (IMEM_DEPTH),
        .DMEM_DEPTH (DMEM_DEPTH)
    ) mips_pipeline_i (
        .i_clk              (i_clk),
        .i_reset            (i_reset),
        .i_du_data          (i_du_data),
        .i_du_inst_addr_wr  (i_du_inst_addr_wr),
        .i_du_write_en      (i_du_write_en),
        .i_du_read_en       (i_du_read_en),
        .o_du_halt          (o_du_halt),
        .o_du_regs_mem_data (o_du_regs_mem_data),
        .o_du_mem_data      (o_du_mem_data)
    );

    always #2 i_clk = ~i_clk;                // 4 ns period

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1, "stopping at first error");
    endtask

    // Cycle budget guard
    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, halt never asserted", cycle_count);
            abort_run();
        end
    end

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        assert (actual === expected) else begin
            $display("mismatch %s expected 0x%08h actual 0x%08h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic step();
        @(posedge i_clk);
        #0.5;                                // Drive just after the edge
    endtask

    task automatic reset_dut();
        step();
        i_reset      = 1'b1;
        i_du_read_en = 1'b0;
        repeat (4) step();
        i_reset = 1'b0;
        @(negedge i_clk);
        check_value("o_du_halt after reset", 32'h0, {31'b0, o_du_halt});
    endtask

    task automatic load_program(input int p);
        for (int k = 0; k < prog_len[p]; k++) begin
            step();
            i_du_write_en     = 1'b1;
            i_du_inst_addr_wr = word_t'(k);  // Word index
            i_du_data         = prog_words[p][k];
        end
        step();
        i_du_write_en = 1'b0;
    endtask

    // Loads while halted must be dropped
    task automatic overwrite_program(input int p);
        for (int k = 0; k < prog_len[p]; k++) begin
            step();
            i_du_write_en     = 1'b1;
            i_du_inst_addr_wr = word_t'(k);
            i_du_data         = halt_word();
        end
        step();
        i_du_write_en = 1'b0;
    endtask

    task automatic run_to_halt();
        step();
        i_du_read_en = 1'b1;
        while (o_du_halt !== 1'b1) begin
            @(negedge i_clk);                // Counter guards this wait
        end
        step();
        i_du_read_en = 1'b0;
    endtask

    task automatic check_results(input int p, input int pass);
        for (int i = 0; i < reg_cnt[p]; i++) begin
            step();
            i_du_inst_addr_wr = word_t'(reg_num[p][i]);
            @(negedge i_clk);
            check_value($sformatf("o_du_regs_mem_data r%0d prog %0d run %0d",
                                  reg_num[p][i], p, pass),
                        reg_exp[p][i], o_du_regs_mem_data);
        end
        for (int i = 0; i < mem_cnt[p]; i++) begin
            step();
            i_du_inst_addr_wr = mem_addr[p][i];
            @(negedge i_clk);
            check_value($sformatf("o_du_mem_data addr 0x%0h prog %0d run %0d",
                                  mem_addr[p][i], p, pass),
                        mem_exp[p][i], o_du_mem_data);
        end
    endtask

    // Register 0 entry where r0 writes are discarded
    function automatic void build_zero_program(input int idx);
        start_entry(idx);
        put_word(i_type(OP_ADDI, 0, 0, 16'h1111));
        put_word(r_type(F_ADDU, 1, 0, 0));   // No forward from r0
        put_word(i_type(OP_ADDI, 2, 0, 16'h0003));
        put_word(r_type(F_ADDU, 0, 2, 2));
        put_word(r_type(F_ADDU, 3, 0, 2));
        put_word(halt_word());
        expect_reg(0, 32'h0);
        expect_reg(1, 32'h0);
        expect_reg(2, 32'h3);
        expect_reg(3, 32'h3);
    endfunction

    // Random ADDI chain r1..r16 followed by two ADDU sums
    function automatic void build_random_program(input int idx);
        logic [15:0] imm;
        word_t       sums [17];
        start_entry(idx);
        sums[0] = '0;
        for (int k = 0; k < 16; k++) begin
            imm = 16'($random(seed));
            put_word(i_type(OP_ADDI, k + 1, k, imm));
            sums[k + 1] = sums[k] + sext16(imm);
            expect_reg(k + 1, sums[k + 1]);
        end
        put_word(r_type(F_ADDU, 17, 16, 8));
        expect_reg(17, sums[16] + sums[8]);
        put_word(r_type(F_ADDU, 18, 17, 1));
        expect_reg(18, sums[16] + sums[8] + sums[1]);
        put_word(halt_word());
    endfunction

    // Two runs per entry with load, run, readout and reload
    function automatic int compute_cycle_limit();
        int total;
        total = 0;
        for (int p = 0; p < NUM_PROGS; p++) begin
            total = total + 2 * (3 * prog_len[p] + reg_cnt[p] + mem_cnt[p] + 20);
        end
        return 2 * total;
    endfunction

    initial begin
        i_reset           = 1'b1;
        i_du_data         = '0;
        i_du_inst_addr_wr = '0;
        i_du_write_en     = 1'b0;
        i_du_read_en      = 1'b0;
        build_table();
        build_zero_program(NUM_PROGS - 2);
        build_random_program(NUM_PROGS - 1);
        cycle_limit = compute_cycle_limit();
        for (int p = 0; p < NUM_PROGS; p++) begin
            for (int pass = 0; pass < 2; pass++) begin
                reset_dut();
                if (pass == 0) begin
                    load_program(p);
                end
                run_to_halt();
                check_results(p, pass);
                if (pass == 0) begin
                    overwrite_program(p);    // Second run shows imem unchanged
                end
            end
        end
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/mips_pipeline.sv */
`timescale 1ns/100ps
`default_nettype none

module mips_pipeline #(
    parameter int IMEM_DEPTH = 64,
    parameter int DMEM_DEPTH = 64
) (
    input  logic           i_clk,
    input  logic           i_reset,
    input  cpu_pkg::word_t i_du_data,          // Program word to load
    input  cpu_pkg::word_t i_du_inst_addr_wr,  // Load index and debug address
    input  logic           i_du_write_en,      // Load strobe
    input  logic           i_du_read_en,       // Run level
    output logic           o_du_halt,
    output cpu_pkg::word_t o_du_regs_mem_data, // Register selected by addr[4:0]
    output cpu_pkg::word_t o_du_mem_data       // Data memory word at addr
);
    import cpu_pkg::*;

    word_t     if_instr;                     // IF/ID
    logic      if_valid;
    logic      halt_seen;
    logic      load_en;
    word_t     wb_data;                      // Writeback bus
    reg_addr_t wb_dest;
    logic      wb_reg_write;

    id_ex_if  id_ex_bus ();
    ex_mem_if ex_mem_bus ();

    assign load_en = i_du_write_en && !o_du_halt;   // No loads once halted

    fetch_stage #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) fetch_stage_i (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_run       (i_du_read_en),
        .i_halt_seen (halt_seen),
        .i_load_en   (load_en),
        .i_load_addr (i_du_inst_addr_wr),
        .i_load_data (i_du_data),
        .o_instr     (if_instr),
        .o_valid     (if_valid)
    );

    decode_stage decode_stage_i (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_instr        (if_instr),
        .i_valid        (if_valid),
        .i_wb_data      (wb_data),
        .i_wb_dest      (wb_dest),
        .i_wb_reg_write (wb_reg_write),
        .i_dbg_reg      (i_du_inst_addr_wr[4:0]),
        .o_halt_seen    (halt_seen),
        .o_dbg_reg_data (o_du_regs_mem_data),
        .id_ex          (id_ex_bus)
    );

    execute_stage execute_stage_i (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .id_ex          (id_ex_bus),
        .ex_mem         (ex_mem_bus),
        .ex_mem_fwd     (ex_mem_bus),
        .i_wb_data      (wb_data),
        .i_wb_dest      (wb_dest),
        .i_wb_reg_write (wb_reg_write)
    );

    memory_stage #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) memory_stage_i (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .ex_mem         (ex_mem_bus),
        .i_dbg_addr     (i_du_inst_addr_wr),
        .o_wb_data      (wb_data),
        .o_wb_dest      (wb_dest),
        .o_wb_reg_write (wb_reg_write),
        .o_halt         (o_du_halt),
        .o_dbg_mem_data (o_du_mem_data)
    );

endmodule

`default_nettype wire

/* hw/memory_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module memory_stage #(
    parameter int DMEM_DEPTH = 64
) (
    input  logic               i_clk,
    input  logic               i_reset,
    ex_mem_if.dst              ex_mem,
    input  cpu_pkg::word_t     i_dbg_addr,   // Byte address, as for LW/SW
    output cpu_pkg::word_t     o_wb_data,
    output cpu_pkg::reg_addr_t o_wb_dest,
    output logic               o_wb_reg_write,
    output logic               o_halt,       // Latched, cleared by reset only
    output cpu_pkg::word_t     o_dbg_mem_data
);
    import cpu_pkg::*;

    localparam int AW = $clog2(DMEM_DEPTH);

    word_t         dmem [DMEM_DEPTH];        // Data memory, word wide
    logic [AW-1:0] mem_addr;                 // Word index from the byte address
    word_t         read_data_q;              // MEM/WB payload
    word_t         alu_result_q;
    reg_addr_t     dest_q;
    logic          mem_read_q;               // MEM/WB control
    logic          reg_write_q;
    logic          halt_q;

    assign mem_addr = ex_mem.alu_result[2 +: AW];

    always_ff @(posedge i_clk) begin
        if (ex_mem.mem_write) begin
            dmem[mem_addr] <= ex_mem.write_data;
        end
    end

    assign o_dbg_mem_data = dmem[i_dbg_addr[2 +: AW]];

    // MEM/WB payload
    always_ff @(posedge i_clk) begin
        read_data_q  <= dmem[mem_addr];
        alu_result_q <= ex_mem.alu_result;
        dest_q       <= ex_mem.dest;
    end

    // MEM/WB control and the halt latch
    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            mem_read_q  <= 1'b0;
            reg_write_q <= 1'b0;
            halt_q      <= 1'b0;
            o_halt      <= 1'b0;
        end else begin
            mem_read_q  <= ex_mem.mem_read;
            reg_write_q <= ex_mem.reg_write;
            halt_q      <= ex_mem.halt;
            if (halt_q) begin
                o_halt <= 1'b1;              // HALT leaves MEM/WB, all older done
            end
        end
    end

    // Writeback select
    assign o_wb_data      = mem_read_q ? read_data_q : alu_result_q;
    assign o_wb_dest      = dest_q;
    assign o_wb_reg_write = reg_write_q;

endmodule

`default_nettype wire

/* hw/execute_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
    input  logic               i_clk,
    input  logic               i_reset,
    id_ex_if.dst               id_ex,
    ex_mem_if.src              ex_mem,
    ex_mem_if.fwd              ex_mem_fwd,   // Same EX/MEM register, read back
    input  cpu_pkg::word_t     i_wb_data,    // MEM/WB forward source
    input  cpu_pkg::reg_addr_t i_wb_dest,
    input  logic               i_wb_reg_write
);
    import cpu_pkg::*;

    word_t operand_a;                        // rs after forwarding
    word_t operand_b;                        // rt after forwarding, also store data
    word_t alu_b;
    word_t alu_result;

    // Pending write to a nonzero register that matches the source
    function automatic logic hit(input logic wr, input reg_addr_t dest,
                                 input reg_addr_t src);
        return wr && dest != '0 && dest == src;
    endfunction

    // Youngest result wins, EX/MEM before MEM/WB
    always_comb begin
        if (hit(ex_mem_fwd.reg_write, ex_mem_fwd.dest, id_ex.rs)) begin
            operand_a = ex_mem_fwd.alu_result;
        end else if (hit(i_wb_reg_write, i_wb_dest, id_ex.rs)) begin
            operand_a = i_wb_data;
        end else begin
            operand_a = id_ex.data_1;
        end

        if (hit(ex_mem_fwd.reg_write, ex_mem_fwd.dest, id_ex.rt)) begin
            operand_b = ex_mem_fwd.alu_result;
        end else if (hit(i_wb_reg_write, i_wb_dest, id_ex.rt)) begin
            operand_b = i_wb_data;
        end else begin
            operand_b = id_ex.data_2;
        end
    end

    assign alu_b = id_ex.alu_src ? id_ex.imm : operand_b;

    // ALU
    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD: alu_result = operand_a + alu_b;
            ALU_SUB: alu_result = operand_a - alu_b;
            ALU_AND: alu_result = operand_a & alu_b;
            ALU_OR:  alu_result = operand_a | alu_b;
            ALU_XOR: alu_result = operand_a ^ alu_b;
            ALU_SLT: alu_result = {31'b0, $signed(operand_a) < $signed(alu_b)};
            default: alu_result = '0;
        endcase
    end

    // EX/MEM control
    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            ex_mem.mem_read  <= 1'b0;
            ex_mem.mem_write <= 1'b0;
            ex_mem.reg_write <= 1'b0;
            ex_mem.halt      <= 1'b0;
        end else begin
            ex_mem.mem_read  <= id_ex.mem_read;
            ex_mem.mem_write <= id_ex.mem_write;
            ex_mem.reg_write <= id_ex.reg_write;
            ex_mem.halt      <= id_ex.halt;
        end
    end

    // EX/MEM payload
    always_ff @(posedge i_clk) begin
        ex_mem.alu_result <= alu_result;
        ex_mem.write_data <= operand_b;
        ex_mem.dest       <= id_ex.dest;
    end

endmodule

`default_nettype wire

/* hw/decode_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
    input  logic               i_clk,
    input  logic               i_reset,
    input  cpu_pkg::word_t     i_instr,      // From IF/ID
    input  logic               i_valid,
    input  cpu_pkg::word_t     i_wb_data,    // Writeback from MEM/WB
    input  cpu_pkg::reg_addr_t i_wb_dest,
    input  logic               i_wb_reg_write,
    input  cpu_pkg::reg_addr_t i_dbg_reg,    // Debug register select
    output logic               o_halt_seen,
    output cpu_pkg::word_t     o_dbg_reg_data,
    id_ex_if.src               id_ex
);
    import cpu_pkg::*;

    word_t     regs [32];                    // Register file
    opcode_e   opcode;
    funct_e    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    word_t     rd_data_1;
    word_t     rd_data_2;
    word_t     imm_ext;
    alu_op_e   alu_op;
    logic      alu_src;
    logic      dest_rt;                      // I-type writes rt
    logic      mem_read;
    logic      mem_write;
    logic      reg_write;
    logic      halt;
    logic      live;                         // Instruction may take effect
    logic      halt_seen_q;                  // Sticky after HALT

    // Write-first read, so a value written this cycle is seen at once
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (i_wb_reg_write && i_wb_dest == addr) begin
            return i_wb_data;
        end
        return regs[addr];
    endfunction

    assign opcode  = opcode_e'(i_instr[OPCODE_MSB -: $bits(opcode_e)]);
    assign funct   = funct_e'(i_instr[FUNCT_LSB +: $bits(funct_e)]);
    assign rs      = i_instr[RS_LSB +: $bits(reg_addr_t)];
    assign rt      = i_instr[RT_LSB +: $bits(reg_addr_t)];
    assign rd      = i_instr[RD_LSB +: $bits(reg_addr_t)];
    assign imm_ext = {{($bits(word_t) - RT_LSB){i_instr[RT_LSB-1]}}, i_instr[RT_LSB-1:0]};
    assign live    = i_valid && !halt_seen_q;

    always_comb begin
        rd_data_1 = read_port(rs);
        rd_data_2 = read_port(rt);
    end

    // Register file, r0 never written
    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb_reg_write && i_wb_dest != '0) begin
            regs[i_wb_dest] <= i_wb_data;
        end
    end

    assign o_dbg_reg_data = regs[i_dbg_reg];  // Array value, no bypass

    // Main decoder, unknown codes become bubbles
    always_comb begin
        alu_op    = ALU_ADD;
        alu_src   = 1'b0;
        dest_rt   = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        halt      = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                reg_write = 1'b1;
                case (funct)
                    F_ADDU:  alu_op = ALU_ADD;
                    F_SUBU:  alu_op = ALU_SUB;
                    F_AND:   alu_op = ALU_AND;
                    F_OR:    alu_op = ALU_OR;
                    F_XOR:   alu_op = ALU_XOR;
                    F_SLT:   alu_op = ALU_SLT;
                    default: reg_write = 1'b0;   // NOP lands here
                endcase
            end
            OP_ADDI: begin
                alu_src   = 1'b1;
                dest_rt   = 1'b1;
                reg_write = 1'b1;
            end
            OP_LW: begin
                alu_src   = 1'b1;
                dest_rt   = 1'b1;
                mem_read  = 1'b1;
                reg_write = 1'b1;
            end
            OP_SW: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            OP_HALT: halt = 1'b1;
            default: ;
        endcase
    end

    // ID/EX control, bubble after reset or after HALT
    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            id_ex.mem_read  <= 1'b0;
            id_ex.mem_write <= 1'b0;
            id_ex.reg_write <= 1'b0;
            id_ex.halt      <= 1'b0;
            halt_seen_q     <= 1'b0;
        end else begin
            id_ex.mem_read  <= live && mem_read;
            id_ex.mem_write <= live && mem_write;
            id_ex.reg_write <= live && reg_write;
            id_ex.halt      <= live && halt;
            if (live && halt) begin
                halt_seen_q <= 1'b1;
            end
        end
    end

    // ID/EX payload
    always_ff @(posedge i_clk) begin
        id_ex.data_1  <= rd_data_1;
        id_ex.data_2  <= rd_data_2;
        id_ex.rs      <= rs;
        id_ex.rt      <= rt;
        id_ex.dest    <= dest_rt ? rt : rd;
        id_ex.imm     <= imm_ext;
        id_ex.alu_op  <= alu_op;
        id_ex.alu_src <= alu_src;
    end

    assign o_halt_seen = halt_seen_q;

endmodule

`default_nettype wire

/* hw/fetch_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_stage #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic           i_clk,
    input  logic           i_reset,
    input  logic           i_run,            // Run level from the debug port
    input  logic           i_halt_seen,      // HALT already decoded
    input  logic           i_load_en,        // Program load strobe
    input  cpu_pkg::word_t i_load_addr,      // Word index of the load
    input  cpu_pkg::word_t i_load_data,
    output cpu_pkg::word_t o_instr,          // IF/ID instruction
    output logic           o_valid           // IF/ID holds a real instruction
);
    import cpu_pkg::*;

    localparam int AW = $clog2(IMEM_DEPTH);

    word_t         imem [IMEM_DEPTH];        // Instruction memory
    logic [AW-1:0] pc;                       // Word index of next fetch
    logic          advance;

    assign advance = i_run && !i_halt_seen;  // Issue one per cycle while running

    // Load port, word indexed
    always_ff @(posedge i_clk) begin
        if (i_load_en) begin
            imem[i_load_addr[AW-1:0]] <= i_load_data;
        end
    end

    // PC and IF/ID register
    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            pc      <= '0;
            o_instr <= NOP_WORD;
            o_valid <= 1'b0;
        end else if (advance) begin
            o_instr <= imem[pc];
            o_valid <= 1'b1;
            pc      <= pc + 1'b1;            // Wraps at the memory end
        end else begin
            o_instr <= NOP_WORD;             // Bubble, PC holds
            o_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hw/pipe_if.sv */
`timescale 1ns/100ps
`default_nettype none

// ID/EX pipeline register contents
interface id_ex_if;
    import cpu_pkg::*;

    word_t     data_1;                       // rs value after write-first bypass
    word_t     data_2;                       // rt value after write-first bypass
    reg_addr_t rs;                           // Source numbers for forwarding
    reg_addr_t rt;
    reg_addr_t dest;                         // rd or rt, already chosen
    word_t     imm;                          // Sign-extended immediate
    alu_op_e   alu_op;
    logic      alu_src;                      // Use imm as ALU operand B
    logic      mem_read;                     // Load, also selects writeback data
    logic      mem_write;                    // Store
    logic      reg_write;
    logic      halt;                         // HALT travelling down the pipe

    modport src (output data_1, data_2, rs, rt, dest, imm, alu_op, alu_src,
                 mem_read, mem_write, reg_write, halt);
    modport dst (input  data_1, data_2, rs, rt, dest, imm, alu_op, alu_src,
                 mem_read, mem_write, reg_write, halt);
endinterface

// EX/MEM pipeline register contents
interface ex_mem_if;
    import cpu_pkg::*;

    word_t     alu_result;                   // Result or memory byte address
    word_t     write_data;                   // Store data, forwarded
    reg_addr_t dest;
    logic      mem_read;
    logic      mem_write;
    logic      reg_write;
    logic      halt;

    modport src (output alu_result, write_data, dest, mem_read, mem_write,
                 reg_write, halt);
    modport dst (input  alu_result, write_data, dest, mem_read, mem_write,
                 reg_write, halt);
    modport fwd (input  alu_result, dest, reg_write);    // Forwarding taps only
endinterface

`default_nettype wire

/* hw/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;             // Data and instruction word
    typedef logic [4:0]  reg_addr_t;         // Register number

    // Instruction field positions
    localparam int OPCODE_MSB = 31;          // Top of the 6-bit opcode
    localparam int RS_LSB     = 21;          // First source register
    localparam int RT_LSB     = 16;          // Second source, or I-type dest
    localparam int RD_LSB     = 11;          // R-type destination
    localparam int FUNCT_LSB  = 0;           // R-type function field

    // Primary opcodes
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,                    // ALU register-register group
        OP_ADDI  = 6'h08,                    // Add sign-extended immediate
        OP_LW    = 6'h23,                    // Load word
        OP_SW    = 6'h2B,                    // Store word
        OP_HALT  = 6'h3F                     // Stop the core
    } opcode_e;

    // R-type function codes
    typedef enum logic [5:0] {
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_SLT  = 6'h2A                       // Signed compare
    } funct_e;

    // ALU operations, decode to execute
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    // All-zero word, an R-type with no valid funct, so it writes nothing
    localparam word_t NOP_WORD = '0;

endpackage

`default_nettype wire
